// File: Makefile
TOP := memory_system_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir

// File: bench/memory_control_properties.sv
/*
  concurrent checks on the memory controller bus
  - one ram operation at a time
  - at most one data wait released per cycle
  - invalidate only alongside a pending snoop wait
  bound into memory_control
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

module memory_control_properties (
  input logic CLK,
  input logic nRST,
  input logic ram_ren,
  input logic ram_wen,
  input logic [`CPUS-1:0] dwait,
  input logic [`CPUS-1:0] ccwait,
  input logic [`CPUS-1:0] ccinv
);

  // single ram port, read and write are exclusive
  one_ram_op: assert property (@(posedge CLK) disable iff (!nRST) !(ram_ren && ram_wen))
    else $error("ram_ren and ram_wen high in the same cycle");

  // only the serviced core sees dwait low
  one_dwait: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(~dwait))
    else $error("more than one dwait low in one cycle");

  // an invalidate always rides on the snoop wait of the same core
  inv_with_wait: assert property (@(posedge CLK) disable iff (!nRST) (ccinv & ~ccwait) == '0)
    else $error("ccinv high without ccwait on the same core");

endmodule

bind memory_control memory_control_properties i_properties (
  .CLK     (CLK),
  .nRST    (nRST),
  .ram_ren (ccif.ram_ren),
  .ram_wen (ccif.ram_wen),
  .dwait   (ccif.dwait),
  .ccwait  (ccif.ccwait),
  .ccinv   (ccif.ccinv)
);

// File: bench/memory_system_tb.sv
/*
  testbench for the dual-core memory system
  - clock, reset and both caches emulated on falling edges
  - transaction table of fetches, write-backs and coherent misses
  - reference memory, typed compare tasks and a closing report
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

module memory_system_tb;
  import cpu_types_pkg::*;

  typedef enum logic [2:0] {
    IFETCH, IFETCH_BOTH, WRITE_BACK, WRITE_BACK_BOTH, BUS_RD, BUS_RDX
  } kind_t;

  typedef struct packed {
    kind_t kind;
    logic  core;        // requesting core
    word_t addr;        // block address, or fetch address
    logic  peer_dirty;  // peer holds the block modified
  } txn_t;

  localparam int NTESTS  = 14;
  localparam int TIMEOUT = 50;  // cycles allowed per wait

  logic CLK, nRST;
  logic [`CPUS-1:0] iren, dren, dwen, cctrans, ccwrite;
  word_t [`CPUS-1:0] iaddr, daddr, dstore;
  logic [`CPUS-1:0] iwait, dwait, ccwait, ccinv;
  word_t [`CPUS-1:0] iload, dload, ccsnoopaddr;

  word_t ref_mem [`RAM_DEPTH];  // expected ram contents
  txn_t tbl [NTESTS];
  kind_t kind;
  word_t rand_blk;
  logic lru_model;              // core expected first on a fetch tie
  int errors, checks, err0;
  bit timed_out;

  memory_system i_dut (
    .CLK (CLK), .nRST (nRST),
    .iren (iren), .iaddr (iaddr), .dren (dren), .dwen (dwen),
    .daddr (daddr), .dstore (dstore), .cctrans (cctrans), .ccwrite (ccwrite),
    .iwait (iwait), .iload (iload), .dwait (dwait), .dload (dload),
    .ccwait (ccwait), .ccinv (ccinv), .ccsnoopaddr (ccsnoopaddr)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic int ridx(word_t a);
    return int'((a >> 2) % `RAM_DEPTH);  // word address wraps at the depth
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // returns on the falling edge where a selected wait line is low
  task automatic wait_low(input bit instr, input logic [1:0] mask, output int core);
    logic [1:0] w;
    core = -1;
    for (int n = 0; n < TIMEOUT && core < 0; n++)
    begin
      @(negedge CLK);
      w = instr ? iwait : dwait;
      for (int c = 1; c >= 0; c--)
        if (mask[c] && !w[c]) core = c;
    end
    if (core < 0)
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: %s of core mask %b never fell", instr ? "iwait" : "dwait", mask);
    end
  endtask

  task automatic fetch_instr(input logic [1:0] mask, input word_t addr);
    int c;
    logic exp_core;
    iaddr[0] = addr;
    iaddr[1] = (mask == 2'b11) ? addr + 32'h4 : addr;  // pair reads neighbouring words
    iren = mask;
    while (iren != '0 && !timed_out)
    begin
      exp_core = (iren == 2'b11) ? lru_model : iren[1];  // lone request served for its core
      wait_low(1'b1, iren, c);
      if (c >= 0)
      begin
        check_bit("served fetch core", 1'(c), exp_core);
        check_word($sformatf("iload[%0d]", c), iload[c], ref_mem[ridx(iaddr[c])]);
        lru_model = ~1'(c);  // served core becomes most recent
        @(negedge CLK);
        iren[c] = 1'b0;
      end
    end
    iren = '0;
  endtask

  task automatic write_back_blocks(input logic [1:0] mask, input word_t addr);
    word_t blk [2][2];
    int words [2];
    int c;
    bit first_seen;
    for (c = 0; c < 2; c++)
    begin
      blk[c][0] = $urandom;
      blk[c][1] = $urandom;
      words[c]  = 0;
      daddr[c]  = addr + ((mask == 2'b11 && c == 1) ? 32'h40 : 32'h0);
      dstore[c] = blk[c][0];
    end
    first_seen = 1'b0;
    dwen = mask;
    while (dwen != '0 && !timed_out)
    begin
      wait_low(1'b0, dwen, c);
      if (c >= 0)
      begin
        if (!first_seen)
          check_bit("first write-back core", 1'(c), ~mask[0]);  // core 0 has priority
        first_seen = 1'b1;
        ref_mem[ridx(daddr[c] + 4 * words[c])] = blk[c][words[c]];
        words[c]++;
        @(negedge CLK);
        if (words[c] == 2)
          dwen[c] = 1'b0;
        else
          dstore[c] = blk[c][1];  // second word after the first release
      end
    end
    dwen = '0;
  endtask

  task automatic snoop_read(input logic r, input word_t addr, input bit excl, input bit dirty);
    logic p;
    word_t fwd [2];
    word_t exp;
    int c, n;
    p = ~r;
    fwd[0] = $urandom;
    fwd[1] = $urandom;
    daddr[r]   = addr;
    dren[r]    = 1'b1;
    cctrans[r] = 1'b1;
    ccwrite[r] = excl;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end while (!ccwait[p] && n < TIMEOUT);
    if (!ccwait[p])
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: ccwait of core %0d never rose for the snoop", p);
      return;
    end
    check_word("ccsnoopaddr", ccsnoopaddr[p], addr);
    check_bit("ccinv before lookup", ccinv[p], 1'b0);
    // peer answers the snoop with dirty data on its dstore
    cctrans[p] = 1'b1;
    ccwrite[p] = dirty;
    daddr[p]   = addr;
    dstore[p]  = fwd[0];
    for (int w = 0; w < 2 && !timed_out; w++)
    begin
      wait_low(1'b0, 2'b01 << r, c);
      if (c >= 0)
      begin
        exp = dirty ? fwd[w] : ref_mem[ridx(addr + 4 * w)];
        check_word($sformatf("dload[%0d] word %0d", r, w), dload[r], exp);
        check_bit("peer ccwait", ccwait[p], 1'b1);
        check_bit("peer ccinv", ccinv[p], excl);
        ref_mem[ridx(addr + 4 * w)] = exp;  // forwarded block also lands in ram
        @(negedge CLK);
        dstore[p] = fwd[1];
      end
    end
    if (!timed_out)
    begin
      check_bit("ccwait after end", ccwait[p], 1'b0);
      check_bit("ccinv after end", ccinv[p], 1'b0);
    end
    dren    = '0;
    cctrans = '0;
    ccwrite = '0;
  endtask

  initial
  begin
    void'($urandom(32'h1a2e));
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    lru_model = 1'b0;
    nRST    = 1'b0;
    iren    = '0;
    dren    = '0;
    dwen    = '0;
    cctrans = '0;
    ccwrite = '0;
    iaddr   = '0;
    daddr   = '0;
    dstore  = '0;
    for (int i = 0; i < `RAM_DEPTH; i++)
      ref_mem[i] = '0;  // ram model starts cleared

    rand_blk = $urandom & 32'h3f8;  // block aligned, inside the array
    tbl[0]  = '{WRITE_BACK,      1'b0, rand_blk,     1'b0};
    tbl[1]  = '{BUS_RD,          1'b1, rand_blk,     1'b0};
    tbl[2]  = '{IFETCH_BOTH,     1'b0, rand_blk,     1'b0};
    tbl[3]  = '{IFETCH_BOTH,     1'b0, 32'h040,      1'b0};
    tbl[4]  = '{IFETCH,          1'b0, 32'h100,      1'b0};
    tbl[5]  = '{IFETCH_BOTH,     1'b0, rand_blk,     1'b0};
    tbl[6]  = '{BUS_RD,          1'b0, 32'h080,      1'b1};
    tbl[7]  = '{IFETCH,          1'b1, 32'h080,      1'b0};
    tbl[8]  = '{IFETCH,          1'b0, 32'h084,      1'b0};
    tbl[9]  = '{BUS_RDX,         1'b1, 32'h0c8,      1'b1};
    tbl[10] = '{BUS_RDX,         1'b0, 32'h140,      1'b0};
    tbl[11] = '{WRITE_BACK_BOTH, 1'b0, 32'h180,      1'b0};
    tbl[12] = '{IFETCH,          1'b1, 32'h1c4,      1'b0};
    tbl[13] = '{BUS_RD,          1'b1, 32'h180,      1'b0};

    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    err0 = errors;
    for (int c = 0; c < `CPUS; c++)
    begin
      check_bit("iwait after reset", iwait[c], 1'b1);
      check_bit("dwait after reset", dwait[c], 1'b1);
      check_bit("ccwait after reset", ccwait[c], 1'b0);
      check_bit("ccinv after reset", ccinv[c], 1'b0);
      check_word("ccsnoopaddr after reset", ccsnoopaddr[c], '0);
    end
    $display("reset values            : %s", (errors == err0) ? "ok" : "failed");

    for (int t = 0; t < NTESTS && !timed_out; t++)
    begin
      err0 = errors;
      kind = tbl[t].kind;
      case (kind)
        IFETCH:          fetch_instr(2'b01 << tbl[t].core, tbl[t].addr);
        IFETCH_BOTH:     fetch_instr(2'b11, tbl[t].addr);
        WRITE_BACK:      write_back_blocks(2'b01 << tbl[t].core, tbl[t].addr);
        WRITE_BACK_BOTH: write_back_blocks(2'b11, tbl[t].addr);
        BUS_RD:          snoop_read(tbl[t].core, tbl[t].addr, 1'b0, tbl[t].peer_dirty);
        default:         snoop_read(tbl[t].core, tbl[t].addr, 1'b1, tbl[t].peer_dirty);
      endcase
      $display("test %2d %-15s core %0d addr %h dirty %0d : %s", t, kind.name(),
               tbl[t].core, tbl[t].addr, tbl[t].peer_dirty, (errors == err0) ? "ok" : "failed");
    end

    $display("%0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: common/cache_control_if.sv
/*
  bus between the two caches, the coherence controller and the ram
  modports
  - cc      coherence controller
  - ram     ram model
  - caches  cache side, driven from the top level ports
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

interface cache_control_if;
  import cpu_types_pkg::*;

  // cache requests, one bit or word per core
  logic  [`CPUS-1:0] iren, dren, dwen;
  word_t [`CPUS-1:0] iaddr, daddr, dstore;

  // cache replies
  logic  [`CPUS-1:0] iwait, dwait;  // low for one cycle per word
  word_t [`CPUS-1:0] iload, dload;

  // coherence
  logic  [`CPUS-1:0] cctrans, ccwrite;  // miss in flight / exclusive or dirty
  logic  [`CPUS-1:0] ccwait, ccinv;     // snoop pending / drop the line
  word_t [`CPUS-1:0] ccsnoopaddr;

  // single ram port
  logic      ram_ren, ram_wen;
  word_t     ram_addr, ram_store, ram_load;
  ramstate_t ram_state;

  modport cc (
    input  iren, dren, dwen, iaddr, daddr, dstore, cctrans, ccwrite,
    input  ram_state, ram_load,
    output iwait, dwait, iload, dload, ccwait, ccinv, ccsnoopaddr,
    output ram_ren, ram_wen, ram_addr, ram_store
  );

  modport ram (
    input  ram_ren, ram_wen, ram_addr, ram_store,
    output ram_state, ram_load
  );

  modport caches (
    output iren, dren, dwen, iaddr, daddr, dstore, cctrans, ccwrite,
    input  iwait, dwait, iload, dload, ccwait, ccinv, ccsnoopaddr
  );

endinterface

// File: common/cpu_params.svh
/*
  sizes shared across the memory system
  word width, core count, ram depth and ram latency
*/
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W     32   // bits per address and data word
`define CPUS       2    // cores on the coherent bus

// ram model defaults
`define RAM_DEPTH  256  // words held by the array
`define RAM_LAT    2    // busy cycles ahead of each access

`endif

// File: common/cpu_types_pkg.sv
/*
  types shared by the memory system
  - word_t         one address or data word
  - ramstate_t     state reported back by the ram
  - dcache_addr_t  data address seen as a word or as cache fields
*/
`include "cpu_params.svh"

package cpu_types_pkg;

  // addresses and data use the same width
  typedef logic [`WORD_W-1:0] word_t;

  // ram progress as seen by the controller
  typedef enum logic [1:0] {
    FREE,    // idle or request just taken
    BUSY,    // latency still running
    ACCESS,  // read data valid, write lands
    ERROR    // decoded, never raised by the model
  } ramstate_t;

  // data cache address layout
  // 8 sets of two-word blocks, tag takes the rest
  typedef union packed {
    word_t raw;             // plain byte address
    struct packed {
      logic [25:0] tag;
      logic [2:0]  idx;     // set index
      logic        blkoff;  // word within the block
      logic [1:0]  bytoff;  // always zero for word accesses
    } fld;
  } dcache_addr_t;

endpackage

// File: memory_control/memory_control.sv
/*
  memory controller for two cores on one ram port
  - fixed priority arbiter, write-backs ahead of misses ahead of fetches
  - snoop fsm with cache-to-cache forwarding of dirty blocks
  - peer invalidation on exclusive misses
  - lru choice between two fetches in the same cycle
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

module memory_control (
  input logic CLK,
  input logic nRST,
  cache_control_if.cc ccif
);
  import cpu_types_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    WRITE_BACK0, WRITE_BACK1,  // requester block to ram
    SNOOP,                     // waiting on the peer lookup
    LOAD0, LOAD1,              // clean peer, block from ram
    FORWARD0, FORWARD1,        // dirty peer, block to ram and requester
    INSTR
  } state_t;

  state_t state, nxt_state;
  logic serviced, nxt_serviced;  // core owning the transaction
  logic lru, nxt_lru;            // core served first on a fetch tie
  logic [`CPUS-1:0] ccwait, nxt_ccwait;
  logic [`CPUS-1:0] ccinv, nxt_ccinv;
  word_t [`CPUS-1:0] snoopaddr, nxt_snoopaddr;

  logic peer;
  logic phase;     // word of the block being moved
  logic ram_done;  // ram finished the current word
  logic ram_fail;
  dcache_addr_t blk_addr, word_addr;

  // first byte of the block holding addr
  function automatic word_t block_base(word_t addr);
    dcache_addr_t a;
    a.raw = addr;
    a.fld.blkoff = 1'b0;
    a.fld.bytoff = '0;
    return a.raw;
  endfunction

  assign peer     = ~serviced;
  assign ram_done = (ccif.ram_state == ACCESS);
  assign ram_fail = (ccif.ram_state == ERROR);
  assign phase    = (state == WRITE_BACK1) || (state == LOAD1) || (state == FORWARD1);

  // word address of this phase, block offset replaced by the phase
  always_comb
  begin
    blk_addr.raw = ccif.daddr[serviced];
    word_addr = blk_addr;
    word_addr.fld.blkoff = phase;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      serviced  <= 1'b0;
      lru       <= 1'b0;  // core 0 wins the first tie
      ccwait    <= '0;
      ccinv     <= '0;
      snoopaddr <= '0;
    end
    else
    begin
      state     <= nxt_state;
      serviced  <= nxt_serviced;
      lru       <= nxt_lru;
      ccwait    <= nxt_ccwait;
      ccinv     <= nxt_ccinv;
      snoopaddr <= nxt_snoopaddr;
    end
  end

  always_comb
  begin
    nxt_state     = state;
    nxt_serviced  = serviced;
    nxt_lru       = lru;
    nxt_ccwait    = ccwait;
    nxt_ccinv     = ccinv;
    nxt_snoopaddr = snoopaddr;

    ccif.iwait     = '1;  // everyone waits unless served
    ccif.dwait     = '1;
    ccif.iload     = {`CPUS{ccif.ram_load}};
    ccif.dload     = {`CPUS{ccif.ram_load}};
    ccif.ram_ren   = 1'b0;
    ccif.ram_wen   = 1'b0;
    ccif.ram_addr  = word_addr.raw;
    ccif.ram_store = ccif.dstore[serviced];

    case (state)
      IDLE:
      begin
        if (ccif.dwen[0])
        begin
          nxt_serviced = 1'b0;
          nxt_state    = WRITE_BACK0;
        end
        else if (ccif.dren[0] && ccif.cctrans[0])
        begin
          nxt_serviced     = 1'b0;
          nxt_ccwait[1]    = 1'b1;  // stall core 1 for the lookup
          nxt_snoopaddr[1] = block_base(ccif.daddr[0]);
          nxt_state        = SNOOP;
        end
        else if (ccif.dwen[1])
        begin
          nxt_serviced = 1'b1;
          nxt_state    = WRITE_BACK0;
        end
        else if (ccif.dren[1] && ccif.cctrans[1])
        begin
          nxt_serviced     = 1'b1;
          nxt_ccwait[0]    = 1'b1;
          nxt_snoopaddr[0] = block_base(ccif.daddr[1]);
          nxt_state        = SNOOP;
        end
        else if (|ccif.iren)
        begin
          // tie goes to the lru core, a lone fetch to its own core
          nxt_serviced = (&ccif.iren) ? lru : ~ccif.iren[0];
          nxt_lru      = (&ccif.iren) ? ~lru : ccif.iren[0];
          nxt_state    = INSTR;
        end
      end

      WRITE_BACK0, WRITE_BACK1:
      begin
        ccif.ram_wen = 1'b1;
        if (ram_done)
        begin
          ccif.dwait[serviced] = 1'b0;  // cache steps dstore to word 1
          nxt_state = (state == WRITE_BACK0) ? WRITE_BACK1 : IDLE;
        end
      end

      SNOOP:
      begin
        // peer answers with cctrans, ccwrite marks a dirty copy
        if (ccif.cctrans[peer])
        begin
          nxt_state       = ccif.ccwrite[peer] ? FORWARD0 : LOAD0;
          nxt_ccinv[peer] = ccif.ccwrite[serviced];  // exclusive miss
        end
      end

      LOAD0, LOAD1:
      begin
        ccif.ram_ren = 1'b1;
        if (ram_done)
        begin
          ccif.dwait[serviced] = 1'b0;
          nxt_state = (state == LOAD0) ? LOAD1 : IDLE;
        end
      end

      FORWARD0, FORWARD1:
      begin
        // dirty word goes to ram and straight across to the requester
        ccif.ram_wen         = 1'b1;
        ccif.ram_store       = ccif.dstore[peer];
        ccif.dload[serviced] = ccif.dstore[peer];
        if (ram_done)
        begin
          ccif.dwait[serviced] = 1'b0;
          nxt_state = (state == FORWARD0) ? FORWARD1 : IDLE;
        end
      end

      INSTR:
      begin
        ccif.ram_ren  = 1'b1;
        ccif.ram_addr = ccif.iaddr[serviced];
        if (ram_done)
        begin
          ccif.iwait[serviced] = 1'b0;
          nxt_state = IDLE;
        end
      end

      default: nxt_state = IDLE;
    endcase

    // failed access drops back, the held request is retried from idle
    if (ram_fail)
      nxt_state = IDLE;

    // snoop side released when the transaction ends
    if (nxt_state == IDLE)
    begin
      nxt_ccwait = '0;
      nxt_ccinv  = '0;
    end
  end

  assign ccif.ccwait      = ccwait;
  assign ccif.ccinv       = ccinv;
  assign ccif.ccsnoopaddr = snoopaddr;

endmodule

// File: rtl/memory_system.sv
/*
  memory system top level
  plain per-core cache ports onto the shared bus, the coherence
  controller and the ram model behind it
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

module memory_system (
  input  logic CLK,
  input  logic nRST,
  // requests from the two caches
  input  logic [`CPUS-1:0] iren,
  input  cpu_types_pkg::word_t [`CPUS-1:0] iaddr,
  input  logic [`CPUS-1:0] dren,
  input  logic [`CPUS-1:0] dwen,
  input  cpu_types_pkg::word_t [`CPUS-1:0] daddr,
  input  cpu_types_pkg::word_t [`CPUS-1:0] dstore,
  input  logic [`CPUS-1:0] cctrans,
  input  logic [`CPUS-1:0] ccwrite,
  // replies and snoop traffic back to the caches
  output logic [`CPUS-1:0] iwait,
  output cpu_types_pkg::word_t [`CPUS-1:0] iload,
  output logic [`CPUS-1:0] dwait,
  output cpu_types_pkg::word_t [`CPUS-1:0] dload,
  output logic [`CPUS-1:0] ccwait,
  output logic [`CPUS-1:0] ccinv,
  output cpu_types_pkg::word_t [`CPUS-1:0] ccsnoopaddr
);

  cache_control_if ccif ();

  // cache side of the bus
  assign ccif.iren    = iren;
  assign ccif.iaddr   = iaddr;
  assign ccif.dren    = dren;
  assign ccif.dwen    = dwen;
  assign ccif.daddr   = daddr;
  assign ccif.dstore  = dstore;
  assign ccif.cctrans = cctrans;
  assign ccif.ccwrite = ccwrite;

  assign iwait       = ccif.iwait;
  assign iload       = ccif.iload;
  assign dwait       = ccif.dwait;
  assign dload       = ccif.dload;
  assign ccwait      = ccif.ccwait;
  assign ccinv       = ccif.ccinv;
  assign ccsnoopaddr = ccif.ccsnoopaddr;

  memory_control i_memory_control (
    .CLK  (CLK),
    .nRST (nRST),
    .ccif (ccif.cc)
  );

  // depth and latency from the shared defaults
  ram_model i_ram_model (
    .CLK   (CLK),
    .nRST  (nRST),
    .ramif (ccif.ram)
  );

endmodule

// File: rtl/ram_model.sv
/*
  behavioral ram behind the memory controller
  word array plus a latency counter giving FREE, BUSY and ACCESS
  for every held read or write request
*/
`timescale 1ns/100ps
`include "cpu_params.svh"

module ram_model #(
  parameter int DEPTH = `RAM_DEPTH,  // words in the array
  parameter int LAT   = `RAM_LAT     // busy cycles per word
) (
  input logic CLK,
  input logic nRST,
  cache_control_if.ram ramif
);
  import cpu_types_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(LAT + 2);

  word_t mem [DEPTH];
  logic [CNT_W-1:0] cnt;  // cycles since the request was taken
  logic req;
  word_t waddr;           // byte address down to a word address
  logic [IDX_W-1:0] idx;

  assign req   = ramif.ram_ren | ramif.ram_wen;
  assign waddr = ramif.ram_addr >> 2;
  assign idx   = IDX_W'(waddr % DEPTH);  // wraps past the end

  // first cycle of a request reads FREE, then LAT busy cycles
  always_comb
  begin
    if (!req)
      ramif.ram_state = FREE;
    else if (cnt == CNT_W'(LAT + 1))
      ramif.ram_state = ACCESS;
    else if (cnt != '0)
      ramif.ram_state = BUSY;
    else
      ramif.ram_state = FREE;
  end

  // restart on a dropped request and after each access
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      cnt <= '0;
    else if (!req || (ramif.ram_state == ACCESS))
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  // array comes up cleared like a freshly loaded image
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = '0;
  end

  always_ff @(posedge CLK)
  begin
    if (ramif.ram_wen && (ramif.ram_state == ACCESS))
      mem[idx] <= ramif.ram_store;
  end

  assign ramif.ram_load = mem[idx];  // read data valid on ACCESS

endmodule

// File: vlog.f
+incdir+common
common/cpu_types_pkg.sv
common/cache_control_if.sv
memory_control/memory_control.sv
rtl/ram_model.sv
rtl/memory_system.sv
bench/memory_control_properties.sv
bench/memory_system_tb.sv
